// File: rtl/cpuPkg.sv
// Opcode, function and operation enums, Tnew/Tuse width, reset PC, link and register count
`default_nettype none

package cpuPkg;

    // Primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        opcSpecial = 6'h00,
        opcJ       = 6'h02,
        opcJal     = 6'h03,
        opcBeq     = 6'h04,
        opcBne     = 6'h05,
        opcAddiu   = 6'h09,
        opcOri     = 6'h0d,
        opcLui     = 6'h0f,
        opcLb      = 6'h20,
        opcLw      = 6'h23,
        opcLbu     = 6'h24,
        opcSb      = 6'h28,
        opcSw      = 6'h2b
    } opcodeT;

    // Function field of special opcode, bits 5:0
    typedef enum logic [5:0] {
        fnSll  = 6'h00,
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnSlt  = 6'h2a
    } functT;

    // Decoded operation carried down the pipe, opNop marks bubbles
    typedef enum logic [4:0] {
        opNop, opAddu, opSubu, opAnd, opOr, opSlt, opSll,
        opOri, opAddiu, opLui, opLw, opLb, opLbu, opSw, opSb,
        opBeq, opBne, opJ, opJal
    } opT;

    localparam int          tWidth   = 2;
    localparam logic [31:0] resetPc  = 32'h0000_3000;
    localparam logic [4:0]  raReg    = 5'd31;
    localparam int          regCount = 32;

endpackage

`default_nettype wire

// File: rtl/fetchStage.sv
// Fetch stage: program counter, next-PC select and F/D pipeline register
`default_nettype none

module fetchStage (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  logic        branchTaken,
    input  logic [31:0] branchTarget,
    input  logic [31:0] instrData,
    output logic [31:0] PC,
    output logic [31:0] instrD,
    output logic [31:0] pcD
);
    import cpuPkg::*;

    // Taken branch in decode redirects the fetch after its delay slot
    always_ff @(posedge clk) begin
        if (reset) begin
            PC     <= resetPc;
            instrD <= 32'd0;
            pcD    <= resetPc;
        end else if (!stall) begin
            PC     <= branchTaken ? branchTarget : PC + 32'd4;
            instrD <= instrData;
            pcD    <= PC;
        end
    end

endmodule

`default_nettype wire

// File: rtl/decodeStage.sv
// Decode stage: decoder, forwarded operand read, branch resolution, Tuse/Tnew and D/E register
`default_nettype none

module decodeStage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stall,
    input  logic [31:0]               instrD,
    input  logic [31:0]               pcD,
    input  logic [4:0]                fwdAddrE,
    input  logic [31:0]               fwdDataE,
    input  logic [4:0]                fwdAddrM,
    input  logic [31:0]               fwdDataM,
    input  logic [31:0]               rd1,
    input  logic [31:0]               rd2,
    output logic [4:0]                ra1,
    output logic [4:0]                ra2,
    output logic                      branchTaken,
    output logic [31:0]               branchTarget,
    output logic [cpuPkg::tWidth-1:0] tuseRs,
    output logic [cpuPkg::tWidth-1:0] tuseRt,
    output logic [4:0]                srcRs,
    output logic [4:0]                srcRt,
    output cpuPkg::opT                opE,
    output logic [31:0]               pcE,
    output logic [31:0]               rsValE,
    output logic [31:0]               rtValE,
    output logic [4:0]                rsE,
    output logic [4:0]                rtE,
    output logic [15:0]               imm16E,
    output logic [4:0]                shamtE,
    output logic [4:0]                wAddrE,
    output logic [31:0]               wDataE,
    output logic [cpuPkg::tWidth-1:0] tnewE
);
    import cpuPkg::*;

    opT                opD;
    logic [4:0]        rs;
    logic [4:0]        rt;
    logic [4:0]        rd;
    logic [4:0]        wAddrD;
    logic [tWidth-1:0] tnewD;
    logic [31:0]       rsVal;
    logic [31:0]       rtVal;
    logic [31:0]       pcPlus4;
    logic [31:0]       branchOffset;

    assign rs  = instrD[25:21];
    assign rt  = instrD[20:16];
    assign rd  = instrD[15:11];
    assign ra1 = rs;
    assign ra2 = rt;

    // Execute value counts only once final, i.e. the link of a jal
    function automatic logic [31:0] pickOperand(input logic [4:0] addr, input logic [31:0] rfVal);
        if (addr != 5'd0 && tnewE == '0 && addr == fwdAddrE) begin
            return fwdDataE;
        end else if (addr != 5'd0 && addr == fwdAddrM) begin
            return fwdDataM;
        end
        return rfVal;
    endfunction

    always_comb begin
        rsVal = pickOperand(rs, rd1);
        rtVal = pickOperand(rt, rd2);
    end

    always_comb begin
        case (opcodeT'(instrD[31:26]))
            opcSpecial: begin
                case (functT'(instrD[5:0]))
                    fnAddu:  opD = opAddu;
                    fnSubu:  opD = opSubu;
                    fnAnd:   opD = opAnd;
                    fnOr:    opD = opOr;
                    fnSlt:   opD = opSlt;
                    fnSll:   opD = (instrD == 32'd0) ? opNop : opSll;
                    default: opD = opNop;
                endcase
            end
            opcJ:     opD = opJ;
            opcJal:   opD = opJal;
            opcBeq:   opD = opBeq;
            opcBne:   opD = opBne;
            opcAddiu: opD = opAddiu;
            opcOri:   opD = opOri;
            opcLui:   opD = opLui;
            opcLw:    opD = opLw;
            opcLb:    opD = opLb;
            opcLbu:   opD = opLbu;
            opcSw:    opD = opSw;
            opcSb:    opD = opSb;
            default:  opD = opNop;
        endcase
    end

    // Source use times and result ready times per operation
    always_comb begin
        srcRs  = 5'd0;
        srcRt  = 5'd0;
        tuseRs = '0;
        tuseRt = '0;
        wAddrD = 5'd0;
        tnewD  = '0;
        case (opD)
            opAddu, opSubu, opAnd, opOr, opSlt: begin
                srcRs  = rs;
                srcRt  = rt;
                tuseRs = tWidth'(1);
                tuseRt = tWidth'(1);
                wAddrD = rd;
                tnewD  = tWidth'(1);
            end
            opSll: begin
                srcRt  = rt;
                tuseRt = tWidth'(1);
                wAddrD = rd;
                tnewD  = tWidth'(1);
            end
            opOri, opAddiu, opLui: begin
                srcRs  = (opD == opLui) ? 5'd0 : rs;
                tuseRs = tWidth'(1);
                wAddrD = rt;
                tnewD  = tWidth'(1);
            end
            opLw, opLb, opLbu: begin
                srcRs  = rs;
                tuseRs = tWidth'(1);
                wAddrD = rt;
                tnewD  = tWidth'(2);
            end
            opSw, opSb: begin
                srcRs  = rs;
                srcRt  = rt;
                tuseRs = tWidth'(1);
                tuseRt = tWidth'(1);
            end
            // Compared right here, so needed at once
            opBeq, opBne: begin
                srcRs = rs;
                srcRt = rt;
            end
            opJal:   wAddrD = raReg;
            default: ;
        endcase
    end

    assign pcPlus4      = pcD + 32'd4;
    assign branchOffset = {{14{instrD[15]}}, instrD[15:0], 2'b00};
    assign branchTarget = (opD == opJ || opD == opJal)
                        ? {pcPlus4[31:28], instrD[25:0], 2'b00}
                        : pcPlus4 + branchOffset;

    always_comb begin
        case (opD)
            opBeq:      branchTaken = (rsVal == rtVal);
            opBne:      branchTaken = (rsVal != rtVal);
            opJ, opJal: branchTaken = 1'b1;
            default:    branchTaken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || stall) begin
            opE    <= opNop;
            wAddrE <= 5'd0;
            tnewE  <= '0;
        end else begin
            opE    <= opD;
            wAddrE <= wAddrD;
            tnewE  <= tnewD;
        end
        pcE    <= pcD;
        rsValE <= rsVal;
        rtValE <= rtVal;
        rsE    <= srcRs;
        rtE    <= srcRt;
        imm16E <= instrD[15:0];
        shamtE <= instrD[10:6];
        // Link value of jal
        wDataE <= pcD + 32'd8;
    end

    // No encoding leaks into execute as an undefined operation
    assert property (@(posedge clk) disable iff (reset) !$isunknown(opE) && opE <= opJal)
        else $error("decode produced an out-of-range operation");

endmodule

`default_nettype wire

// File: rtl/regFile.sv
// General register file, 32 x 32, with write-through and hardwired zero register
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic [4:0]  wAddr,
    input  logic [31:0] wData,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);
    import cpuPkg::*;

    logic [31:0] regs [regCount];

    // Address 0 doubles as "no write"
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wAddr != 5'd0) begin
            regs[wAddr] <= wData;
        end
    end

    // Writeback in this cycle is seen by decode reads
    assign rd1 = (ra1 == 5'd0) ? 32'd0 : (ra1 == wAddr) ? wData : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? 32'd0 : (ra2 == wAddr) ? wData : regs[ra2];

endmodule

`default_nettype wire

// File: rtl/executeStage.sv
// Execute stage: operand forwarding, ALU and E/M pipeline register
`default_nettype none

module executeStage (
    input  logic                      clk,
    input  logic                      reset,
    input  cpuPkg::opT                opE,
    input  logic [31:0]               pcE,
    input  logic [31:0]               rsValE,
    input  logic [31:0]               rtValE,
    input  logic [4:0]                rsE,
    input  logic [4:0]                rtE,
    input  logic [15:0]               imm16E,
    input  logic [4:0]                shamtE,
    input  logic [4:0]                wAddrE,
    input  logic [31:0]               wDataE,
    input  logic [cpuPkg::tWidth-1:0] tnewE,
    input  logic [4:0]                fwdAddrW,
    input  logic [31:0]               fwdDataW,
    output logic [4:0]                fwdAddrM,
    output logic [31:0]               fwdDataM,
    output cpuPkg::opT                opM,
    output logic [31:0]               pcM,
    output logic [31:0]               aluM,
    output logic [31:0]               rtValM,
    output logic [4:0]                wAddrM,
    output logic [cpuPkg::tWidth-1:0] tnewM
);
    import cpuPkg::*;

    logic [31:0] srcA;
    logic [31:0] srcB;
    logic [31:0] signImm;
    logic [31:0] aluOut;

    // Memory stage first, it holds the younger result
    function automatic logic [31:0] forward(input logic [4:0] addr, input logic [31:0] regVal);
        if (addr != 5'd0 && addr == fwdAddrM) begin
            return fwdDataM;
        end else if (addr != 5'd0 && addr == fwdAddrW) begin
            return fwdDataW;
        end
        return regVal;
    endfunction

    assign signImm = {{16{imm16E[15]}}, imm16E};

    always_comb begin
        srcA = forward(rsE, rsValE);
        srcB = forward(rtE, rtValE);
        case (opE)
            opAddu:  aluOut = srcA + srcB;
            opSubu:  aluOut = srcA - srcB;
            opAnd:   aluOut = srcA & srcB;
            opOr:    aluOut = srcA | srcB;
            opSlt:   aluOut = {31'd0, $signed(srcA) < $signed(srcB)};
            opSll:   aluOut = srcB << shamtE;
            opOri:   aluOut = srcA | {16'd0, imm16E};
            opLui:   aluOut = {imm16E, 16'd0};
            opJal:   aluOut = wDataE;
            // Address for loads and stores
            opAddiu, opLw, opLb, opLbu, opSw, opSb: aluOut = srcA + signImm;
            default: aluOut = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            opM    <= opNop;
            wAddrM <= 5'd0;
            tnewM  <= '0;
        end else begin
            opM    <= opE;
            wAddrM <= wAddrE;
            tnewM  <= (tnewE == '0) ? '0 : tnewE - tWidth'(1);
        end
        pcM    <= pcE;
        aluM   <= aluOut;
        rtValM <= srcB;
    end

    // A load still waiting on memory publishes nothing
    assign fwdAddrM = (tnewM == '0) ? wAddrM : 5'd0;
    assign fwdDataM = aluM;

endmodule

`default_nettype wire

// File: rtl/memoryStage.sv
// Memory stage: bridge byte enables and store data, M/W pipeline register
`default_nettype none

module memoryStage (
    input  logic                      clk,
    input  logic                      reset,
    input  cpuPkg::opT                opM,
    input  logic [31:0]               pcM,
    input  logic [31:0]               aluM,
    input  logic [31:0]               rtValM,
    input  logic [4:0]                wAddrM,
    input  logic [cpuPkg::tWidth-1:0] tnewM,
    input  logic [31:0]               BrRData,
    output logic [31:0]               BrPC,
    output logic [31:0]               BrAddr,
    output logic [31:0]               BrWData,
    output logic [3:0]                BrWE,
    output cpuPkg::opT                opW,
    output logic [31:0]               pcW,
    output logic [31:0]               memWordW,
    output logic [1:0]                offsetW,
    output logic [4:0]                wAddrW,
    output logic [31:0]               resultW
);
    import cpuPkg::*;

    assign BrPC   = pcM;
    assign BrAddr = aluM;

    // Byte store repeats the byte on every lane
    assign BrWData = (opM == opSb) ? {4{rtValM[7:0]}} : rtValM;

    always_comb begin
        case (opM)
            opSw:    BrWE = 4'b1111;
            opSb:    BrWE = 4'b0001 << aluM[1:0];
            default: BrWE = 4'b0000;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            opW    <= opNop;
            wAddrW <= 5'd0;
        end else begin
            opW    <= opM;
            wAddrW <= wAddrM;
        end
        pcW      <= pcM;
        memWordW <= BrRData;
        offsetW  <= aluM[1:0];
        resultW  <= aluM;
    end

    assert property (@(posedge clk) disable iff (reset)
        BrWE inside {4'b0000, 4'b1111} || $onehot(BrWE))
        else $error("illegal byte enable pattern on bridge");

endmodule

`default_nettype wire

// File: rtl/writebackStage.sv
// Writeback stage: load byte extraction, sign handling and register write select
`default_nettype none

module writebackStage (
    input  cpuPkg::opT  opW,
    input  logic [31:0] memWordW,
    input  logic [1:0]  offsetW,
    input  logic [4:0]  wAddrW,
    input  logic [31:0] resultW,
    output logic [4:0]  regWAddr,
    output logic [31:0] regWData,
    output logic [4:0]  fwdAddrW,
    output logic [31:0] fwdDataW
);
    import cpuPkg::*;

    logic [7:0] loadByte;
    logic       writesReg;

    assign loadByte = memWordW[8*offsetW +: 8];

    always_comb begin
        case (opW)
            opLw:    regWData = memWordW;
            opLb:    regWData = {{24{loadByte[7]}}, loadByte};
            opLbu:   regWData = {24'd0, loadByte};
            default: regWData = resultW;
        endcase
    end

    assign writesReg = !(opW inside {opNop, opSw, opSb, opBeq, opBne, opJ});
    assign regWAddr  = writesReg ? wAddrW : 5'd0;
    assign fwdAddrW  = regWAddr;
    assign fwdDataW  = regWData;

endmodule

`default_nettype wire

// File: rtl/pipelineControl.sv
// Hazard unit: Tuse against Tnew comparison for the decode stall
`default_nettype none

module pipelineControl (
    input  logic [4:0]                srcRs,
    input  logic [4:0]                srcRt,
    input  logic [cpuPkg::tWidth-1:0] tuseRs,
    input  logic [cpuPkg::tWidth-1:0] tuseRt,
    input  logic [cpuPkg::tWidth-1:0] tnewE,
    input  logic [4:0]                wAddrE,
    input  logic [cpuPkg::tWidth-1:0] tnewM,
    input  logic [4:0]                wAddrM,
    output logic                      stall
);
    import cpuPkg::*;

    // Source needed before its producer in E or M can deliver it
    function automatic logic mustWait(input logic [4:0] src, input logic [tWidth-1:0] tuse);
        logic fromE;
        logic fromM;
        fromE = (src == wAddrE) && (tuse < tnewE);
        fromM = (src == wAddrM) && (tuse < tnewM);
        return (src != 5'd0) && (fromE || fromM);
    endfunction

    always_comb begin
        stall = mustWait(srcRs, tuseRs) || mustWait(srcRt, tuseRt);
    end

endmodule

`default_nettype wire

// File: rtl/cpu.sv
// Processor top: five pipeline stages, register file and hazard unit
`default_nettype none

module cpu (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] PC,
    input  logic [31:0] instrData,
    output logic [31:0] BrPC,
    output logic [31:0] BrAddr,
    output logic [31:0] BrWData,
    output logic [3:0]  BrWE,
    input  logic [31:0] BrRData
);
    import cpuPkg::*;

    // Fetch and decode
    logic [31:0]       instrD, pcD;
    logic              stall, branchTaken;
    logic [31:0]       branchTarget;
    logic [4:0]        ra1, ra2, srcRs, srcRt;
    logic [31:0]       rd1, rd2;
    logic [tWidth-1:0] tuseRs, tuseRt;
    // Execute
    opT                opE;
    logic [31:0]       pcE, rsValE, rtValE, wDataE;
    logic [4:0]        rsE, rtE, shamtE, wAddrE;
    logic [15:0]       imm16E;
    logic [tWidth-1:0] tnewE;
    // Memory
    opT                opM;
    logic [31:0]       pcM, aluM, rtValM, fwdDataM;
    logic [4:0]        wAddrM, fwdAddrM;
    logic [tWidth-1:0] tnewM;
    // Writeback
    opT                opW;
    logic [31:0]       memWordW, resultW, regWData, fwdDataW;
    logic [1:0]        offsetW;
    logic [4:0]        wAddrW, regWAddr, fwdAddrW;

    fetchStage fetch (
        .clk, .reset, .stall, .branchTaken, .branchTarget, .instrData,
        .PC, .instrD, .pcD
    );

    decodeStage decode (
        .clk, .reset, .stall, .instrD, .pcD,
        .fwdAddrE(wAddrE), .fwdDataE(wDataE), .fwdAddrM, .fwdDataM,
        .rd1, .rd2, .ra1, .ra2, .branchTaken, .branchTarget,
        .tuseRs, .tuseRt, .srcRs, .srcRt,
        .opE, .pcE, .rsValE, .rtValE, .rsE, .rtE, .imm16E, .shamtE,
        .wAddrE, .wDataE, .tnewE
    );

    regFile regs (
        .clk, .reset, .ra1, .ra2, .wAddr(regWAddr), .wData(regWData), .rd1, .rd2
    );

    executeStage execute (
        .clk, .reset, .opE, .pcE, .rsValE, .rtValE, .rsE, .rtE, .imm16E, .shamtE,
        .wAddrE, .wDataE, .tnewE, .fwdAddrW, .fwdDataW,
        .fwdAddrM, .fwdDataM, .opM, .pcM, .aluM, .rtValM, .wAddrM, .tnewM
    );

    memoryStage memory (
        .clk, .reset, .opM, .pcM, .aluM, .rtValM, .wAddrM, .tnewM, .BrRData,
        .BrPC, .BrAddr, .BrWData, .BrWE,
        .opW, .pcW(), .memWordW, .offsetW, .wAddrW, .resultW
    );

    writebackStage writeback (
        .opW, .memWordW, .offsetW, .wAddrW, .resultW,
        .regWAddr, .regWData, .fwdAddrW, .fwdDataW
    );

    pipelineControl control (
        .srcRs, .srcRt, .tuseRs, .tuseRt, .tnewE, .wAddrE, .tnewM, .wAddrM, .stall
    );

    // Worst case is a branch on a load, two bubbles before the value lands
    assert property (@(posedge clk) disable iff (reset) stall [*2] |=> !stall)
        else $error("pipeline stalled for more than two cycles");

endmodule

`default_nettype wire

// File: tests/cpuModel.svh
// Instruction encoders, random program generator, memory images and instruction-level model
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

logic [31:0] imem [imemWords];
logic [31:0] modelRegs [32];
logic [31:0] modelMem [dmemWords];
logic [31:0] expPc [$];
logic [31:0] expAddr [$];
logic [31:0] expData [$];
logic [3:0]  expWe [$];
int          loopIdx;

function automatic logic [31:0] rType(functT fn, logic [4:0] rs, logic [4:0] rt,
                                      logic [4:0] rd, logic [4:0] sh);
    return {opcSpecial, rs, rt, rd, sh, fn};
endfunction

function automatic logic [31:0] iType(opcodeT opc, logic [4:0] rs, logic [4:0] rt,
                                      logic [15:0] imm);
    return {opc, rs, rt, imm};
endfunction

// Small pool so that neighbours often depend on each other
function automatic logic [4:0] pickReg();
    if ($urandom_range(0, 9) == 0) begin
        return 5'd31;
    end
    return 5'($urandom_range(0, 7));
endfunction

// Initial data word, a function of the whole word address and the program
function automatic logic [31:0] fillWord(int idx, int prog);
    return (32'(idx) * 32'h9e37_79b1) ^ {8'(prog), 8'(idx), 16'h5ac3};
endfunction

task automatic genProgram();
    int          kind;
    int          maxK;
    logic        prevBranch;
    logic [31:0] jumpTo;
    prevBranch = 1'b0;
    for (int i = 0; i < imemWords; i++) begin
        imem[i] = 32'd0;
    end
    for (int i = 0; i < bodyLen; i++) begin
        kind = $urandom_range(0, 17);
        // No branch in a delay slot or without room for its slot
        if (kind >= 14 && (prevBranch || i > bodyLen - 2)) begin
            kind = kind - 14;
        end
        prevBranch = (kind >= 14);
        maxK = (bodyLen - 1 - i < 4) ? bodyLen - 1 - i : 4;
        jumpTo = resetPc + 32'(4 * (i + 1 + $urandom_range(1, maxK)));
        case (kind)
            0: imem[i] = rType(fnAddu, pickReg(), pickReg(), pickReg(), 5'd0);
            1: imem[i] = rType(fnSubu, pickReg(), pickReg(), pickReg(), 5'd0);
            2: imem[i] = rType(fnAnd, pickReg(), pickReg(), pickReg(), 5'd0);
            3: imem[i] = rType(fnOr, pickReg(), pickReg(), pickReg(), 5'd0);
            4: imem[i] = rType(fnSlt, pickReg(), pickReg(), pickReg(), 5'd0);
            5: imem[i] = rType(fnSll, 5'd0, pickReg(), pickReg(), 5'($urandom));
            6: imem[i] = iType(opcOri, pickReg(), pickReg(), 16'($urandom));
            7: imem[i] = iType(opcAddiu, pickReg(), pickReg(), 16'($urandom));
            8: imem[i] = iType(opcLui, 5'd0, pickReg(), 16'($urandom));
            // Memory accesses use base $0 to stay inside the 1 KB window
            9: imem[i] = iType(opcLw, 5'd0, pickReg(), {6'd0, 8'($urandom), 2'b00});
            10: imem[i] = iType(opcLb, 5'd0, pickReg(), 16'($urandom_range(0, 1023)));
            11: imem[i] = iType(opcLbu, 5'd0, pickReg(), 16'($urandom_range(0, 1023)));
            12: imem[i] = iType(opcSw, 5'd0, pickReg(), {6'd0, 8'($urandom), 2'b00});
            13: imem[i] = iType(opcSb, 5'd0, pickReg(), 16'($urandom_range(0, 1023)));
            14: imem[i] = iType(opcBeq, pickReg(), pickReg(), 16'((jumpTo - resetPc) / 4 - i - 1));
            15: imem[i] = iType(opcBne, pickReg(), pickReg(), 16'((jumpTo - resetPc) / 4 - i - 1));
            16: imem[i] = {opcJ, jumpTo[27:2]};
            default: imem[i] = {opcJal, jumpTo[27:2]};
        endcase
    end
    // Epilogue dumps the register file, then spins
    for (int r = 1; r < 32; r++) begin
        imem[bodyLen + r - 1] = iType(opcSw, 5'd0, 5'(r), 16'(16'h0300 + 4 * r));
    end
    loopIdx = bodyLen + 31;
    imem[loopIdx] = iType(opcBeq, 5'd0, 5'd0, 16'hffff);
endtask

function automatic void writeReg(logic [4:0] r, logic [31:0] v);
    if (r != 5'd0) begin
        modelRegs[r] = v;
    end
endfunction

function automatic void recordStore(logic [31:0] pc, logic [31:0] addr, logic [31:0] data,
                                    logic [3:0] we);
    expPc.push_back(pc);
    expAddr.push_back(addr);
    expData.push_back(data);
    expWe.push_back(we);
    for (int b = 0; b < 4; b++) begin
        if (we[b]) begin
            modelMem[addr[9:2]][8*b +: 8] = data[8*b +: 8];
        end
    end
endfunction

// Runs the program one instruction at a time, with one delay slot after control transfers
task automatic runModel();
    logic [31:0] w;
    logic [31:0] pc;
    logic [31:0] npc;
    logic [31:0] nextNpc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sImm;
    logic [31:0] addr;
    logic [7:0]  byteVal;
    logic [4:0]  rt;
    logic [4:0]  rd;
    int          steps;
    pc = resetPc;
    npc = resetPc + 32'd4;
    steps = 0;
    for (int r = 0; r < 32; r++) begin
        modelRegs[r] = 32'd0;
    end
    expPc.delete();
    expAddr.delete();
    expData.delete();
    expWe.delete();
    while (int'((pc - resetPc) >> 2) != loopIdx && steps < 1000) begin
        w = imem[(pc - resetPc) >> 2];
        rt = w[20:16];
        rd = w[15:11];
        a = modelRegs[w[25:21]];
        b = modelRegs[rt];
        sImm = {{16{w[15]}}, w[15:0]};
        addr = a + sImm;
        byteVal = modelMem[addr[9:2]][8*addr[1:0] +: 8];
        nextNpc = npc + 32'd4;
        case (opcodeT'(w[31:26]))
            opcSpecial: begin
                case (functT'(w[5:0]))
                    fnAddu: writeReg(rd, a + b);
                    fnSubu: writeReg(rd, a - b);
                    fnAnd:  writeReg(rd, a & b);
                    fnOr:   writeReg(rd, a | b);
                    fnSlt:  writeReg(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                    fnSll:  writeReg(rd, b << w[10:6]);
                    default: ;
                endcase
            end
            opcAddiu: writeReg(rt, a + sImm);
            opcOri:   writeReg(rt, a | {16'd0, w[15:0]});
            opcLui:   writeReg(rt, {w[15:0], 16'd0});
            opcLw:    writeReg(rt, modelMem[addr[9:2]]);
            opcLb:    writeReg(rt, {{24{byteVal[7]}}, byteVal});
            opcLbu:   writeReg(rt, {24'd0, byteVal});
            opcSw:    recordStore(pc, addr, b, 4'b1111);
            opcSb:    recordStore(pc, addr, {4{b[7:0]}}, 4'b0001 << addr[1:0]);
            opcBeq:   nextNpc = (a == b) ? npc + (sImm << 2) : nextNpc;
            opcBne:   nextNpc = (a != b) ? npc + (sImm << 2) : nextNpc;
            opcJ:     nextNpc = {npc[31:28], w[25:0], 2'b00};
            opcJal: begin
                nextNpc = {npc[31:28], w[25:0], 2'b00};
                writeReg(5'd31, pc + 32'd8);
            end
            default: ;
        endcase
        pc = npc;
        npc = nextNpc;
        steps++;
    end
endtask

`endif

// File: tests/cpuTb.sv
// Testbench for the pipelined processor: clock, reset, memory model and store checking
`default_nettype none

module cpuTb;
    timeunit 1ns;
    timeprecision 1ps;

    import cpuPkg::*;

    localparam int imemWords     = 128;
    localparam int dmemWords     = 256;
    localparam int bodyLen       = 40;
    localparam int progCount     = 10;
    localparam int timeoutCycles = 2000;

    logic        clk;
    logic        reset;
    logic [31:0] PC;
    logic [31:0] instrData;
    logic [31:0] BrPC;
    logic [31:0] BrAddr;
    logic [31:0] BrWData;
    logic [3:0]  BrWE;
    logic [31:0] BrRData;
    logic [31:0] fetchIdx;
    logic [31:0] dmem [dmemWords];
    int          seenStores;
    int          errorCount;

    `include "cpuModel.svh"

    cpu i_dut (
        .clk, .reset, .PC, .instrData, .BrPC, .BrAddr, .BrWData, .BrWE, .BrRData
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Both ports answer in the same cycle
    assign fetchIdx  = (PC - resetPc) >> 2;
    assign instrData = (fetchIdx < imemWords) ? imem[fetchIdx[6:0]] : 32'd0;
    assign BrRData   = dmem[BrAddr[9:2]];

    task automatic checkEq(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            errorCount++;
            $display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Stores are sampled mid-cycle, away from the clock edge
    always @(negedge clk) begin
        if (!reset && BrWE != 4'b0000) begin
            if (seenStores >= expPc.size()) begin
                $display("sim failed");
                $fatal(1, "processor made a store the model does not make, at pc %h", BrPC);
            end
            checkEq("store pc", BrPC, expPc[seenStores]);
            checkEq("store address", BrAddr, expAddr[seenStores]);
            checkEq("store byte enables", {28'd0, BrWE}, {28'd0, expWe[seenStores]});
            for (int b = 0; b < 4; b++) begin
                if (BrWE[b]) begin
                    checkEq("store byte", {24'd0, BrWData[8*b +: 8]},
                            {24'd0, expData[seenStores][8*b +: 8]});
                    dmem[BrAddr[9:2]][8*b +: 8] = BrWData[8*b +: 8];
                end
            end
            seenStores++;
        end
    end

    task automatic runProgram(int prog);
        int cycles;
        @(posedge clk);
        reset <= 1'b1;
        genProgram();
        for (int i = 0; i < dmemWords; i++) begin
            dmem[i] = fillWord(i, prog);
            modelMem[i] = fillWord(i, prog);
        end
        runModel();
        seenStores = 0;
        @(posedge clk);
        @(negedge clk);
        checkEq("PC in reset", PC, resetPc);
        @(posedge clk);
        reset <= 1'b0;
        cycles = 0;
        while (seenStores < expPc.size()) begin
            if (cycles >= timeoutCycles) begin
                $display("sim failed");
                $fatal(1, "processor stalled: %0d of %0d stores seen in program %0d",
                       seenStores, expPc.size(), prog);
            end
            @(posedge clk);
            cycles++;
        end
        // Let the self-loop spin to catch any stray store
        repeat (20) @(posedge clk);
    endtask

    initial begin
        reset = 1'b1;
        seenStores = 0;
        errorCount = 0;
        void'($urandom(32'hc9b5));
        for (int p = 0; p < progCount; p++) begin
            runProgram(p);
        end
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+tests
rtl/cpuPkg.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/regFile.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/writebackStage.sv
rtl/pipelineControl.sv
rtl/cpu.sv
tests/cpuTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = cpuTb
FILELIST = files.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
